// ==== uart_stim.txt ====
# LOOP word : 16-bit command in hex, sent on tx and looped back into rx
# RAW bits byte perr ferr : 11 line bits with the first bit left, expected byte and flags
# GLITCH n : rx held low for n clocks, no character may follow
LOOP 1234
LOOP a55a
LOOP 0000
LOOP ffff
RAW 01010101001 55 1 0
RAW 01100010110 a3 0 1
LOOP 8001
LOOP 7e81
RAW 00000000001 00 1 0
RAW 01111111100 ff 1 1
GLITCH 1
LOOP beef
LOOP 0f0f
RAW 01000000011 01 1 0
RAW 00000000100 80 0 1
LOOP c35a
LOOP 5aa5
RAW 00011110001 3c 1 0
RAW 01010001101 c5 1 0
LOOP 0001
LOOP 8000
RAW 00111111010 7e 0 1
RAW 00110100100 96 1 1
GLITCH 1
LOOP dead
LOOP 6996
RAW 00100100001 12 1 0
RAW 01110011110 e7 0 1
LOOP 3c3c
LOOP fe01
LOOP 1e2d
LOOP aaaa
LOOP 5555
LOOP 7fff

// ==== build.f ====
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart.sv

// ==== Bender.yml ====
package:
  name: uart_link

sources:
  - files:
      - uart_pkg.sv
      - uart_tx.sv
      - uart_rx.sv
      - uart_top.sv
  - target: simulation
    files:
      - tb_uart.sv

// ==== tb_uart.sv ====
`timescale 1ns/100ps

module tb_uart import uart_pkg::*; ();

   typedef enum {VEC_LOOP, VEC_RAW, VEC_GLITCH} vec_kind_t;

   logic       clk = 1'b0;
   logic       rst_n;
   cmd_word_t  cmd_in;
   logic       cmd_vld;
   logic       cmd_rdy;
   logic       tx;
   logic       rx;
   uart_byte_t read_data;
   logic       read_rdy;
   logic       parity_err;
   logic       frame_err;

   logic       loop_mode;
   rx_result_t strobe_q[$];

   vec_kind_t            vec_kind[$];
   cmd_word_t            vec_word[$];
   logic [CHAR_BITS-1:0] vec_bits[$];
   rx_result_t           vec_exp[$];
   int                   vec_len[$];

   int     err_cnt      = 0;
   int     pass_cnt     = 0;
   int     fail_cnt     = 0;
   int     cycle_cnt    = 0;
   int     cycle_limit  = 0;
   int     random_words = 8;
   integer seed         = 32'h8af1_4707;

   uart_top u_uart_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_in     (cmd_in),
      .cmd_vld    (cmd_vld),
      .cmd_rdy    (cmd_rdy),
      .tx         (tx),
      .rx         (rx),
      .read_data  (read_data),
      .read_rdy   (read_rdy),
      .parity_err (parity_err),
      .frame_err  (frame_err)
   );

   always #50 clk = ~clk;

   // Loopback copies tx to rx through one register stage.
   always @(posedge clk) begin
      if (loop_mode) begin
         rx <= tx;
      end
   end

   // Strobes are captured with the values from the cycle before the edge.
   always @(posedge clk) begin
      if (rst_n && read_rdy) begin
         strobe_q.push_back({read_data, parity_err, frame_err});
      end
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
         $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
         $display("Test failed");
         $finish;
      end
   end

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
      if (actual !== expected) begin
         $display("Error at %0d ns: %s, got 0x%0h, expected 0x%0h", $time, msg, actual,
                  expected);
         err_cnt++;
      end
   endtask

   task automatic add_vector(input vec_kind_t kind, input cmd_word_t word,
                             input logic [CHAR_BITS-1:0] bits, input rx_result_t exp,
                             input int len);
      vec_kind.push_back(kind);
      vec_word.push_back(word);
      vec_bits.push_back(bits);
      vec_exp.push_back(exp);
      vec_len.push_back(len);
   endtask

   task automatic read_stim(output bit ok);
      int                   fd;
      int                   n;
      logic [63:0]          mode;
      logic [8*200-1:0]     rest;
      cmd_word_t            word;
      logic [CHAR_BITS-1:0] bits;
      uart_byte_t           exp_byte;
      logic                 exp_perr;
      logic                 exp_ferr;
      int                   len;
      ok = 1'b1;
      fd = $fopen("uart_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file uart_stim.txt");
         ok = 1'b0;
      end else begin
         while (ok && !$feof(fd)) begin
            mode = '0;
            n = $fscanf(fd, "%s", mode);
            if (n == 1) begin
               if (mode == "#") begin
                  n = $fgets(rest, fd);
               end else if (mode == "LOOP") begin
                  n = $fscanf(fd, "%h", word);
                  add_vector(VEC_LOOP, word, '1, '0, 0);
               end else if (mode == "RAW") begin
                  n = $fscanf(fd, "%b %h %b %b", bits, exp_byte, exp_perr, exp_ferr);
                  add_vector(VEC_RAW, '0, bits, {exp_byte, exp_perr, exp_ferr}, 0);
               end else if (mode == "GLITCH") begin
                  n = $fscanf(fd, "%d", len);
                  add_vector(VEC_GLITCH, '0, '1, '0, len);
               end else begin
                  $display("Unknown vector mode in uart_stim.txt");
                  ok = 1'b0;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic run_loop(input cmd_word_t word);
      logic [FRAME_BITS-1:0] line_bits;
      logic [CHAR_BITS-1:0]  chr;
      uart_byte_t            sent;
      uart_byte_t            exp_byte;
      rx_result_t            got;
      int                    c;
      int                    h;
      int                    i;
      while (!cmd_rdy) @(negedge clk);
      @(posedge clk);
      loop_mode <= 1'b1;
      cmd_in    <= word;
      cmd_vld   <= 1'b1;
      // cmd_vld stays high through the frame so that busy requests must be dropped.
      @(posedge clk);
      cmd_in <= ~word;
      for (c = 0; c <= FRAME_BITS * CLKS_PER_BIT; c++) begin
         @(negedge clk);
         check_value(cmd_rdy, c >= FRAME_BITS * CLKS_PER_BIT, "cmd_rdy during frame");
         if ((c % CLKS_PER_BIT == CLKS_PER_BIT / 2) && (c < FRAME_BITS * CLKS_PER_BIT)) begin
            line_bits[FRAME_BITS-1-c/CLKS_PER_BIT] = tx;
         end
         if (c == (FRAME_BITS - 2) * CLKS_PER_BIT) begin
            @(posedge clk);
            cmd_vld <= 1'b0;
         end
      end
      check_value(tx, 1'b1, "tx idle after frame");
      for (h = 0; h < 2; h++) begin
         chr      = (h == 0) ? line_bits[FRAME_BITS-1 -: CHAR_BITS] : line_bits[CHAR_BITS-1:0];
         exp_byte = (h == 0) ? word[15:8] : word[7:0];
         for (i = 0; i < 8; i++) begin
            sent[i] = chr[CHAR_BITS-2-i];
         end
         check_value(chr[CHAR_BITS-1], 1'b0, "start bit on tx");
         check_value(chr[0], 1'b1, "stop bit on tx");
         check_value(^chr[CHAR_BITS-2:1], 1'b1, "odd parity on tx");
         check_value(sent, exp_byte, "data bits on tx");
      end
      while (strobe_q.size() < 2) @(negedge clk);
      for (h = 0; h < 2; h++) begin
         got      = strobe_q.pop_front();
         exp_byte = (h == 0) ? word[15:8] : word[7:0];
         check_value(got.data, exp_byte, "read_data after loopback");
         check_value(got.parity_err, 1'b0, "parity_err after loopback");
         check_value(got.frame_err, 1'b0, "frame_err after loopback");
      end
   endtask

   task automatic run_raw(input logic [CHAR_BITS-1:0] bits, input rx_result_t exp);
      rx_result_t got;
      int         i;
      @(posedge clk);
      loop_mode <= 1'b0;
      // First line bit is the MSB.
      for (i = CHAR_BITS - 1; i >= 0; i--) begin
         @(posedge clk);
         rx <= bits[i];
         repeat (CLKS_PER_BIT - 1) @(posedge clk);
      end
      @(posedge clk);
      rx <= 1'b1;
      while (strobe_q.size() == 0) @(negedge clk);
      got = strobe_q.pop_front();
      check_value(got.data, exp.data, "read_data of raw character");
      check_value(got.parity_err, exp.parity_err, "parity_err of raw character");
      check_value(got.frame_err, exp.frame_err, "frame_err of raw character");
      repeat (2 * CLKS_PER_BIT) @(posedge clk);
   endtask

   task automatic run_glitch(input int len);
      @(posedge clk);
      loop_mode <= 1'b0;
      @(posedge clk);
      rx <= 1'b0;
      repeat (len) @(posedge clk);
      rx <= 1'b1;
      // A full character plus the receiver latency.
      repeat ((CHAR_BITS + 2) * CLKS_PER_BIT) @(negedge clk);
      check_value(strobe_q.size(), 0, "read_rdy after a short low glitch");
   endtask

   task automatic report_test(input int num, input string kind, input int errs_before);
      if (err_cnt == errs_before) begin
         pass_cnt++;
         $display("Vector %0d (%s): ok", num, kind);
      end else begin
         fail_cnt++;
         $display("Vector %0d (%s): %0d mismatches", num, kind, err_cnt - errs_before);
      end
   endtask

   initial begin
      bit    ok;
      int    idx;
      int    errs_before;
      string kind;
      rst_n     = 1'b0;
      cmd_in    = '0;
      cmd_vld   = 1'b0;
      rx        = 1'b1;
      loop_mode = 1'b0;
      read_stim(ok);
      if (!ok) begin
         $display("Test failed");
         $finish;
      end else begin
         for (idx = 0; idx < random_words; idx++) begin
            add_vector(VEC_LOOP, cmd_word_t'($random(seed)), '1, '0, 0);
         end
         cycle_limit = vec_kind.size() * (FRAME_BITS * CLKS_PER_BIT + 20) + 100;
         repeat (5) @(posedge clk);
         rst_n <= 1'b1;
         @(negedge clk);
         errs_before = err_cnt;
         check_value(cmd_rdy, 1'b1, "cmd_rdy after reset");
         check_value(tx, 1'b1, "tx after reset");
         check_value(read_rdy, 1'b0, "read_rdy after reset");
         report_test(0, "RESET", errs_before);
         for (idx = 0; idx < vec_kind.size(); idx++) begin
            errs_before = err_cnt;
            check_value(strobe_q.size(), 0, "unexpected read_rdy before vector");
            case (vec_kind[idx])
               VEC_LOOP: begin
                  kind = "LOOP";
                  run_loop(vec_word[idx]);
               end
               VEC_RAW: begin
                  kind = "RAW";
                  run_raw(vec_bits[idx], vec_exp[idx]);
               end
               default: begin
                  kind = "GLITCH";
                  run_glitch(vec_len[idx]);
               end
            endcase
            report_test(idx + 1, kind, errs_before);
         end
         errs_before = err_cnt;
         repeat (CHAR_BITS * CLKS_PER_BIT) @(negedge clk);
         check_value(strobe_q.size(), 0, "read_rdy after the last vector");
         report_test(vec_kind.size() + 1, "IDLE", errs_before);
         $display("Summary: %0d vectors passed, %0d vectors failed, %0d mismatches",
                  pass_cnt, fail_cnt, err_cnt);
         if (err_cnt == 0) begin
            $display("Test completed successfully");
         end else begin
            $display("Test failed");
         end
         $finish;
      end
   end

endmodule

// ==== uart_top.sv ====
`timescale 1ns/100ps

module uart_top import uart_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  cmd_word_t  cmd_in,
   input  logic       cmd_vld,
   output logic       cmd_rdy,
   output logic       tx,
   input  logic       rx,
   output uart_byte_t read_data,
   output logic       read_rdy,
   output logic       parity_err,
   output logic       frame_err
);

   rx_result_t rx_result;
   logic       rx_result_vld;

   uart_tx u_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .cmd_rdy (cmd_rdy),
      .tx      (tx)
   );

   uart_rx u_rx (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx         (rx),
      .result     (rx_result),
      .result_vld (rx_result_vld)
   );

   // Receive result split out to the host ports.
   assign read_data  = rx_result.data;
   assign parity_err = rx_result.parity_err;
   assign frame_err  = rx_result.frame_err;
   assign read_rdy   = rx_result_vld;

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx import uart_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       rx,
   output rx_result_t result,
   output logic       result_vld
);

   logic       rx_meta;
   logic       rx_sync;
   rx_state_t  state;
   baud_cnt_t  baud_cnt;
   bit_cnt_t   bit_cnt;
   uart_byte_t data_sr;
   logic       par_acc;
   logic       mid_tick;
   logic       bit_tick;
   logic       last_data;

   // Two flop synchronizer, idles high like the line.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   // Middle of the start bit, two clocks after the detected edge.
   assign mid_tick = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));

   // One full bit after the previous sample.
   assign bit_tick = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

   assign last_data = (bit_cnt == bit_cnt_t'($bits(uart_byte_t) - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= RX_IDLE;
         baud_cnt   <= '0;
         bit_cnt    <= '0;
         par_acc    <= 1'b0;
         result     <= '0;
         result_vld <= 1'b0;
      end else begin
         result_vld <= 1'b0;
         baud_cnt   <= baud_cnt + 1'b1;
         unique case (state)
            RX_IDLE: begin
               baud_cnt <= '0;
               if (!rx_sync) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               if (mid_tick) begin
                  baud_cnt <= '0;
                  // High at mid-bit means it was only a glitch.
                  if (!rx_sync) begin
                     state   <= RX_DATA;
                     bit_cnt <= '0;
                     par_acc <= 1'b0;
                  end else begin
                     state <= RX_IDLE;
                  end
               end
            end
            RX_DATA: begin
               if (bit_tick) begin
                  baud_cnt <= '0;
                  par_acc  <= par_acc ^ rx_sync;
                  if (last_data) begin
                     state <= RX_PARITY;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            RX_PARITY: begin
               if (bit_tick) begin
                  baud_cnt <= '0;
                  par_acc  <= par_acc ^ rx_sync;
                  state    <= RX_STOP;
               end
            end
            RX_STOP: begin
               if (bit_tick) begin
                  baud_cnt          <= '0;
                  state             <= RX_IDLE;
                  // Odd parity leaves the accumulator set.
                  result.data       <= data_sr;
                  result.parity_err <= ~par_acc;
                  result.frame_err  <= ~rx_sync;
                  result_vld        <= 1'b1;
               end
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

   // Data arrives LSB first.
   always_ff @(posedge clk) begin
      if ((state == RX_DATA) && bit_tick) begin
         data_sr <= {rx_sync, data_sr[$bits(uart_byte_t)-1:1]};
      end
   end

   a_single_strobe: assert property (
      @(posedge clk) disable iff (!rst_n)
      result_vld |=> !result_vld
   ) else $error("result_vld held for more than one cycle");

   a_strobe_after_stop: assert property (
      @(posedge clk) disable iff (!rst_n)
      result_vld |-> ($past(state) == RX_STOP) && (state != RX_STOP)
   ) else $error("result_vld without a completed stop bit");

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx import uart_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  cmd_word_t cmd_in,
   input  logic      cmd_vld,
   output logic      cmd_rdy,
   output logic      tx
);

   tx_state_t             state;
   baud_cnt_t             baud_cnt;
   bit_cnt_t              bit_cnt;
   logic [FRAME_BITS-1:0] shreg;
   logic [FRAME_BITS-1:0] frame;
   logic                  accept;
   logic                  bit_end;
   logic                  last_bit;

   // Builds one character with the first line bit in the MSB.
   function automatic logic [CHAR_BITS-1:0] build_char(input uart_byte_t b);
      logic [CHAR_BITS-1:0] c;
      c[CHAR_BITS-1] = 1'b0;
      for (int i = 0; i < $bits(uart_byte_t); i++) begin
         c[CHAR_BITS-2-i] = b[i];
      end
      // Odd parity over data and parity bit.
      c[1] = ~^b;
      c[0] = 1'b1;
      return c;
   endfunction

   assign frame = {build_char(cmd_in[15:8]), build_char(cmd_in[7:0])};

   assign accept = cmd_vld && cmd_rdy;

   assign bit_end = (state == TX_SEND) &&
                    (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

   assign last_bit = (bit_cnt == bit_cnt_t'(FRAME_BITS - 1));

   // Control path.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= TX_IDLE;
         cmd_rdy  <= 1'b1;
         tx       <= 1'b1;
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         unique case (state)
            TX_IDLE: begin
               if (accept) begin
                  // Start bit of the high byte goes out at the acceptance edge.
                  state    <= TX_SEND;
                  cmd_rdy  <= 1'b0;
                  tx       <= frame[FRAME_BITS-1];
                  baud_cnt <= '0;
                  bit_cnt  <= '0;
               end
            end
            TX_SEND: begin
               baud_cnt <= baud_cnt + 1'b1;
               if (bit_end) begin
                  baud_cnt <= '0;
                  if (last_bit) begin
                     state   <= TX_IDLE;
                     cmd_rdy <= 1'b1;
                     tx      <= 1'b1;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                     tx      <= shreg[FRAME_BITS-2];
                  end
               end
            end
            default: begin
               state <= TX_IDLE;
            end
         endcase
      end
   end

   // Frame shift register, MSB is the bit on the line.
   always_ff @(posedge clk) begin
      if (accept) begin
         shreg <= frame;
      end else if (bit_end) begin
         shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
      end
   end

   a_tx_idle_high: assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == TX_IDLE) |-> tx
   ) else $error("tx low while transmitter idle");

   a_no_rdy_in_send: assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == TX_SEND) |-> !cmd_rdy
   ) else $error("cmd_rdy high during frame");

endmodule

// ==== uart_pkg.sv ====
package uart_pkg;

   // Clock cycles per serial bit.
   localparam int CLKS_PER_BIT = 4;

   // Start, eight data bits, parity and stop.
   localparam int CHAR_BITS = 11;

   // Two characters per command word.
   localparam int FRAME_BITS = 2 * CHAR_BITS;

   // Host command, bits 15 to 8 go out first.
   typedef logic [15:0] cmd_word_t;

   typedef logic [7:0] uart_byte_t;

   // Bit position within a frame, counts up to FRAME_BITS.
   typedef logic [4:0] bit_cnt_t;

   // Clock position within one bit period.
   typedef logic [1:0] baud_cnt_t;

   typedef struct packed {
      uart_byte_t data;
      logic       parity_err;
      logic       frame_err;
   } rx_result_t;

   typedef enum logic {
      TX_IDLE,
      TX_SEND
   } tx_state_t;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_PARITY,
      RX_STOP
   } rx_state_t;

endpackage
